// File: include/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// cpu word width, also the width of a word address
`define CACHE_WORD_W 16

// words held in one cache line
`define CACHE_LINE_WORDS 4

// address bits that select a word inside a line
`define CACHE_OFFSET_W 2

// address bits that select the set, two sets in total
`define CACHE_SET_W 1

// whatever is left of the address above set and offset
`define CACHE_TAG_W (`CACHE_WORD_W - `CACHE_SET_W - `CACHE_OFFSET_W)

// address layout, msb first
//   [tag][set][offset]
// a line-aligned address has the offset bits cleared

`endif

// File: hdl/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_W-1:0]                     word_t;
    // word 0 sits in the low bits
    typedef logic [`CACHE_WORD_W*`CACHE_LINE_WORDS-1:0]   line_t;
    typedef logic [`CACHE_TAG_W-1:0]                      tag_t;
    typedef logic [`CACHE_SET_W-1:0]                      set_idx_t;
    typedef logic [`CACHE_OFFSET_W-1:0]                   word_off_t;

    typedef struct packed {logic valid; logic dirty; logic recent; tag_t tag;} tag_entry_t;

    typedef struct packed {tag_entry_t way1; tag_entry_t way0;} tag_set_t;

    typedef struct packed {logic en; tag_set_t tags;} tag_wr_t;

    typedef struct packed {logic en; logic way; line_t line;} line_wr_t;

    typedef struct packed {logic valid; logic write; word_t addr; word_t wdata;} cpu_req_t;

    typedef struct packed {logic read_done; logic write_done; word_t rdata;} cpu_resp_t;

    // read and write are never raised together
    typedef struct packed {logic read; logic write; word_t addr; line_t wline;} mem_req_t;

    typedef struct packed {logic read_done; logic write_done; line_t rline;} mem_resp_t;

    typedef enum logic [1:0] {
        check,
        allocate,
        write_back
    } cache_state_e;

endpackage

// File: hdl/cache_tag_array.sv
`timescale 1ns/10ps
`include "cache_params.svh"

module cache_tag_array (
    input  logic                clk,
    input  logic                reset_n,
    input  cache_pkg::word_t    addr,
    input  cache_pkg::tag_wr_t  tag_wr,
    output cache_pkg::tag_set_t tags
);
    import cache_pkg::*;

    localparam int SETS = 1 << `CACHE_SET_W;

    // both ways of a set live in one entry so a write updates them together
    tag_set_t mem [SETS];
    set_idx_t set_idx;

    assign set_idx = addr[`CACHE_SET_W+`CACHE_OFFSET_W-1:`CACHE_OFFSET_W];

    // combinational read at the current request set
    assign tags = mem[set_idx];

    // only two sets, so every entry clears in a single reset cycle
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < SETS; i++) begin
                mem[i] <= '0;
            end
        end else if (tag_wr.en) begin
            mem[set_idx] <= tag_wr.tags;
        end
    end

endmodule

// File: hdl/cache_data_array.sv
`timescale 1ns/10ps
`include "cache_params.svh"

module cache_data_array (
    input  logic                clk,
    input  cache_pkg::word_t    addr,
    input  cache_pkg::line_wr_t line_wr,
    output cache_pkg::line_t    line0,
    output cache_pkg::line_t    line1
);
    import cache_pkg::*;

    localparam int SETS = 1 << `CACHE_SET_W;

    line_t    way0_mem [SETS];
    line_t    way1_mem [SETS];
    set_idx_t set_idx;

    assign set_idx = addr[`CACHE_SET_W+`CACHE_OFFSET_W-1:`CACHE_OFFSET_W];

    assign line0 = way0_mem[set_idx];
    assign line1 = way1_mem[set_idx];

    // one way per cycle, picked by the way bit
    always_ff @(posedge clk) begin
        if (line_wr.en) begin
            if (line_wr.way) begin
                way1_mem[set_idx] <= line_wr.line;
            end else begin
                way0_mem[set_idx] <= line_wr.line;
            end
        end
    end

endmodule

// File: hdl/cache_hit_datapath.sv
`timescale 1ns/10ps
`include "cache_params.svh"

module cache_hit_datapath (
    input  cache_pkg::cpu_req_t cpu_req,
    input  cache_pkg::tag_set_t tags,
    input  cache_pkg::line_t    line0,
    input  cache_pkg::line_t    line1,
    output logic                hit,
    output logic                hit_way,
    output logic                victim_way,
    output logic                victim_dirty,
    output cache_pkg::word_t    victim_addr,
    output cache_pkg::line_t    victim_line,
    output cache_pkg::word_t    rdata,
    output cache_pkg::line_t    merged_line
);
    import cache_pkg::*;

    tag_t       req_tag;
    set_idx_t   req_set;
    word_off_t  req_off;
    logic       hit0;
    logic       hit1;
    line_t      hit_line;
    tag_entry_t victim_entry;

    assign req_tag = cpu_req.addr[`CACHE_WORD_W-1 -: `CACHE_TAG_W];
    assign req_set = cpu_req.addr[`CACHE_SET_W+`CACHE_OFFSET_W-1:`CACHE_OFFSET_W];
    assign req_off = cpu_req.addr[`CACHE_OFFSET_W-1:0];

    // tag compare only counts on a valid entry
    assign hit0    = tags.way0.valid && (tags.way0.tag == req_tag);
    assign hit1    = tags.way1.valid && (tags.way1.tag == req_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit1;

    assign hit_line = hit_way ? line1 : line0;
    assign rdata    = hit_line[req_off*`CACHE_WORD_W +: `CACHE_WORD_W];

    // write data dropped into the hitting line at the word offset
    always_comb begin
        merged_line = hit_line;
        merged_line[req_off*`CACHE_WORD_W +: `CACHE_WORD_W] = cpu_req.wdata;
    end

    // way 0 goes out unless it was the last one used
    assign victim_way   = tags.way0.recent;
    assign victim_entry = victim_way ? tags.way1 : tags.way0;
    assign victim_dirty = victim_entry.valid && victim_entry.dirty;
    assign victim_line  = victim_way ? line1 : line0;

    // rebuild the victim's line address from its stored tag
    assign victim_addr = {victim_entry.tag, req_set, {`CACHE_OFFSET_W{1'b0}}};

endmodule

// File: hdl/cache_ctrl_fsm.sv
`timescale 1ns/10ps
`include "cache_params.svh"

module cache_ctrl_fsm (
    input  logic                 clk,
    input  logic                 reset_n,
    input  cache_pkg::cpu_req_t  cpu_req,
    input  logic                 hit,
    input  logic                 hit_way,
    input  logic                 victim_way,
    input  logic                 victim_dirty,
    input  cache_pkg::word_t     victim_addr,
    input  cache_pkg::line_t     victim_line,
    input  cache_pkg::line_t     merged_line,
    input  cache_pkg::tag_set_t  tags,
    input  cache_pkg::mem_resp_t mem_resp,
    output cache_pkg::tag_wr_t   tag_wr,
    output cache_pkg::line_wr_t  line_wr,
    output cache_pkg::mem_req_t  mem_req,
    output logic                 read_done,
    output logic                 write_done
);
    import cache_pkg::*;

    cache_state_e state_q;
    cache_state_e state_d;
    logic         fill_way_q;
    logic         mem_read_q;
    logic         mem_write_q;
    word_t        mem_addr_q;
    line_t        mem_wline_q;
    word_t        fill_addr;
    tag_entry_t   fill_entry;
    logic         miss;
    logic         wb_done;
    logic         fill_done;

    assign fill_addr  = {cpu_req.addr[`CACHE_WORD_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
    assign fill_entry = '{valid: 1'b1, dirty: 1'b0, recent: 1'b1,
                          tag: cpu_req.addr[`CACHE_WORD_W-1 -: `CACHE_TAG_W]};

    assign miss      = (state_q == check) && cpu_req.valid && !hit;
    assign wb_done   = (state_q == write_back) && mem_resp.write_done;
    assign fill_done = (state_q == allocate) && mem_resp.read_done;

    always_comb begin
        state_d    = state_q;
        tag_wr     = '0;
        tag_wr.tags = tags;
        line_wr    = '0;
        read_done  = 1'b0;
        write_done = 1'b0;
        case (state_q)
            check: begin
                if (cpu_req.valid && hit) begin
                    tag_wr.en = 1'b1;
                    tag_wr.tags.way0.recent = !hit_way;
                    tag_wr.tags.way1.recent = hit_way;
                    if (cpu_req.write) begin
                        if (hit_way) begin
                            tag_wr.tags.way1.dirty = 1'b1;
                        end else begin
                            tag_wr.tags.way0.dirty = 1'b1;
                        end
                        line_wr = '{en: 1'b1, way: hit_way, line: merged_line};
                    end
                    read_done  = !cpu_req.write;
                    write_done = cpu_req.write;
                end else if (miss) begin
                    state_d = victim_dirty ? write_back : allocate;
                end
            end
            write_back: begin
                if (wb_done) begin
                    state_d = allocate;
                end
            end
            allocate: begin
                // fill lands here, the request then hits back in check
                if (fill_done) begin
                    tag_wr.en = 1'b1;
                    if (fill_way_q) begin
                        tag_wr.tags.way1 = fill_entry;
                        tag_wr.tags.way0.recent = 1'b0;
                    end else begin
                        tag_wr.tags.way0 = fill_entry;
                        tag_wr.tags.way1.recent = 1'b0;
                    end
                    line_wr = '{en: 1'b1, way: fill_way_q, line: mem_resp.rline};
                    state_d = check;
                end
            end
            default: state_d = check;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q     <= check;
            fill_way_q  <= 1'b0;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (miss) begin
                fill_way_q  <= victim_way;
                mem_read_q  <= !victim_dirty;
                mem_write_q <= victim_dirty;
            end else if (wb_done) begin
                // straight from write-back into the line read
                mem_write_q <= 1'b0;
                mem_read_q  <= 1'b1;
            end else if (fill_done) begin
                mem_read_q <= 1'b0;
            end
        end
    end

    // address and line held until the matching done bit
    always_ff @(posedge clk) begin
        if (miss) begin
            mem_addr_q  <= victim_dirty ? victim_addr : fill_addr;
            mem_wline_q <= victim_line;
        end else if (wb_done) begin
            mem_addr_q <= fill_addr;
        end
    end

    assign mem_req = '{read: mem_read_q, write: mem_write_q, addr: mem_addr_q,
                       wline: mem_wline_q};

endmodule

// File: hdl/data_cache.sv
`timescale 1ns/10ps

module data_cache (
    input  logic                 clk,
    input  logic                 reset_n,
    input  cache_pkg::cpu_req_t  cpu_req,
    output cache_pkg::cpu_resp_t cpu_resp,
    output cache_pkg::mem_req_t  mem_req,
    input  cache_pkg::mem_resp_t mem_resp
);
    import cache_pkg::*;

    tag_set_t tags;
    tag_wr_t  tag_wr;
    line_t    line0;
    line_t    line1;
    line_wr_t line_wr;
    logic     hit;
    logic     hit_way;
    logic     victim_way;
    logic     victim_dirty;
    word_t    victim_addr;
    line_t    victim_line;
    word_t    rdata;
    line_t    merged_line;
    logic     read_done;
    logic     write_done;

    // arrays are indexed by the live request address
    cache_tag_array i_tag_array (
        .clk     (clk),
        .reset_n (reset_n),
        .addr    (cpu_req.addr),
        .tag_wr  (tag_wr),
        .tags    (tags)
    );

    cache_data_array i_data_array (
        .clk     (clk),
        .addr    (cpu_req.addr),
        .line_wr (line_wr),
        .line0   (line0),
        .line1   (line1)
    );

    cache_hit_datapath i_hit_datapath (
        .cpu_req      (cpu_req),
        .tags         (tags),
        .line0        (line0),
        .line1        (line1),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_line  (victim_line),
        .rdata        (rdata),
        .merged_line  (merged_line)
    );

    cache_ctrl_fsm i_ctrl_fsm (
        .clk          (clk),
        .reset_n      (reset_n),
        .cpu_req      (cpu_req),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_line  (victim_line),
        .merged_line  (merged_line),
        .tags         (tags),
        .mem_resp     (mem_resp),
        .tag_wr       (tag_wr),
        .line_wr      (line_wr),
        .mem_req      (mem_req),
        .read_done    (read_done),
        .write_done   (write_done)
    );

    assign cpu_resp = '{read_done: read_done, write_done: write_done, rdata: rdata};

endmodule

// File: sim/data_cache_tb.sv
`timescale 1ns/10ps

module data_cache_tb;
    import cache_pkg::*;

    localparam int NUM_REQS   = 2000;
    localparam int CLK_PERIOD = 8;
    // budget per request covers a write-back, a fill and the slowest memory
    localparam int TIMEOUT_NS = (NUM_REQS + 20) * 20 * CLK_PERIOD;

    logic      clk;
    logic      reset_n;
    cpu_req_t  cpu_req;
    cpu_resp_t cpu_resp;
    mem_req_t  mem_req;
    mem_resp_t mem_resp;

    // backing store behind the DUT, and the value every word should hold
    word_t mem_words [65536];
    word_t ref_words [65536];

    // two-way tag model, indexed by set then way
    logic m_valid  [2][2];
    logic m_dirty  [2][2];
    logic m_recent [2][2];
    tag_t m_tag    [2][2];

    tag_t tag_pool [4];
    int   miss_count;
    int   wb_count;

    data_cache i_data_cache (
        .clk      (clk),
        .reset_n  (reset_n),
        .cpu_req  (cpu_req),
        .cpu_resp (cpu_resp),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // word k of the line that holds line_addr
    function automatic word_t word_addr(input word_t line_addr, input word_off_t k);
        return {line_addr[15:2], k};
    endfunction

    function automatic line_t ref_line(input word_t a);
        return {ref_words[word_addr(a, 2'd3)], ref_words[word_addr(a, 2'd2)],
                ref_words[word_addr(a, 2'd1)], ref_words[word_addr(a, 2'd0)]};
    endfunction

    task automatic run_request(input logic wr, input word_t addr, input word_t wdata,
                               output logic was_hit);
        logic  s;
        tag_t  tag;
        logic  exp_hit;
        logic  way;
        logic  vict;
        logic  vict_dirty;
        word_t exp_addr;
        logic  seen_mem;
        logic  seen_write;
        word_t seen_addr;
        logic  done;
        s       = addr[2];
        tag     = addr[15:3];
        exp_hit = 1'b0;
        way     = 1'b0;
        if (m_valid[s][0] && m_tag[s][0] == tag) begin
            exp_hit = 1'b1;
            way     = 1'b0;
        end
        if (m_valid[s][1] && m_tag[s][1] == tag) begin
            exp_hit = 1'b1;
            way     = 1'b1;
        end
        // way 0 is replaced unless it was used last
        vict       = m_recent[s][0];
        vict_dirty = m_valid[s][vict] && m_dirty[s][vict];
        exp_addr   = vict_dirty ? {m_tag[s][vict], s, 2'b00} : {addr[15:2], 2'b00};

        @(posedge clk);
        cpu_req <= '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
        seen_mem   = 1'b0;
        seen_write = 1'b0;
        seen_addr  = '0;
        done       = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (!seen_mem && (mem_req.read || mem_req.write)) begin
                seen_mem   = 1'b1;
                seen_write = mem_req.write;
                seen_addr  = mem_req.addr;
            end
            done = wr ? cpu_resp.write_done : cpu_resp.read_done;
        end
        check_value("cpu_resp.other_done", 64'(1'b0),
                    64'(wr ? cpu_resp.read_done : cpu_resp.write_done));
        check_value("hit", 64'(exp_hit), 64'(!seen_mem));
        if (!exp_hit) begin
            check_value("mem_req.write", 64'(vict_dirty), 64'(seen_write));
            check_value("mem_req.addr", 64'(exp_addr), 64'(seen_addr));
            miss_count++;
            if (vict_dirty) begin
                wb_count++;
            end
        end
        if (!wr) begin
            check_value("cpu_resp.rdata", 64'(ref_words[addr]), 64'(cpu_resp.rdata));
        end

        // a miss fills the victim clean, then the request hits there
        if (!exp_hit) begin
            way            = vict;
            m_valid[s][way] = 1'b1;
            m_dirty[s][way] = 1'b0;
            m_tag[s][way]   = tag;
        end
        m_recent[s][way]  = 1'b1;
        m_recent[s][!way] = 1'b0;
        if (wr) begin
            m_dirty[s][way] = 1'b1;
            ref_words[addr] = wdata;
        end
        was_hit = !seen_mem;
    endtask

    // memory model with 0 to 5 cycles of latency
    initial begin
        int    lat;
        logic  is_write;
        word_t line_addr;
        mem_resp = '0;
        forever begin
            @(negedge clk);
            if (reset_n && (mem_req.read || mem_req.write)) begin
                check_value("mem_req.read_and_write", 64'(1'b0),
                            64'(mem_req.read && mem_req.write));
                is_write  = mem_req.write;
                line_addr = mem_req.addr;
                if (is_write) begin
                    // a written-back line carries the newest value of each word
                    check_value("mem_req.wline", ref_line(line_addr), mem_req.wline);
                end
                lat = $urandom_range(5, 0);
                repeat (lat) @(posedge clk);
                @(posedge clk);
                if (is_write) begin
                    mem_words[word_addr(line_addr, 2'd0)] = mem_req.wline[15:0];
                    mem_words[word_addr(line_addr, 2'd1)] = mem_req.wline[31:16];
                    mem_words[word_addr(line_addr, 2'd2)] = mem_req.wline[47:32];
                    mem_words[word_addr(line_addr, 2'd3)] = mem_req.wline[63:48];
                    mem_resp <= '{read_done: 1'b0, write_done: 1'b1, rline: '0};
                end else begin
                    mem_resp <= '{read_done: 1'b1, write_done: 1'b0,
                                  rline: {mem_words[word_addr(line_addr, 2'd3)],
                                          mem_words[word_addr(line_addr, 2'd2)],
                                          mem_words[word_addr(line_addr, 2'd1)],
                                          mem_words[word_addr(line_addr, 2'd0)]}};
                end
                @(posedge clk);
                mem_resp <= '0;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the cache stopped answering requests");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int    i;
        logic  was_hit;
        logic  wr;
        word_t addr;
        void'($urandom(14300));
        reset_n    = 1'b0;
        cpu_req    = '0;
        miss_count = 0;
        wb_count   = 0;
        tag_pool   = '{13'h0000, 13'h0123, 13'h0a5c, 13'h1fff};
        m_valid    = '{'{1'b0, 1'b0}, '{1'b0, 1'b0}};
        m_dirty    = '{'{1'b0, 1'b0}, '{1'b0, 1'b0}};
        m_recent   = '{'{1'b0, 1'b0}, '{1'b0, 1'b0}};
        m_tag      = '{'{13'h0, 13'h0}, '{13'h0, 13'h0}};
        for (i = 0; i < 65536; i++) begin
            mem_words[word_t'(i)] = word_t'($urandom);
            ref_words[word_t'(i)] = mem_words[word_t'(i)];
        end

        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        // idle after reset, nothing may move
        repeat (4) begin
            @(negedge clk);
            check_value("mem_req.read", 64'(1'b0), 64'(mem_req.read));
            check_value("mem_req.write", 64'(1'b0), 64'(mem_req.write));
            check_value("cpu_resp.read_done", 64'(1'b0), 64'(cpu_resp.read_done));
            check_value("cpu_resp.write_done", 64'(1'b0), 64'(cpu_resp.write_done));
        end

        // three tags in set 0, the least recently used one must go
        run_request(1'b0, {tag_pool[0], 1'b0, 2'b01}, '0, was_hit);
        run_request(1'b0, {tag_pool[1], 1'b0, 2'b01}, '0, was_hit);
        run_request(1'b0, {tag_pool[0], 1'b0, 2'b10}, '0, was_hit);
        run_request(1'b0, {tag_pool[2], 1'b0, 2'b11}, '0, was_hit);
        run_request(1'b0, {tag_pool[0], 1'b0, 2'b00}, '0, was_hit);
        check_value("hit", 64'(1'b1), 64'(was_hit));
        run_request(1'b0, {tag_pool[1], 1'b0, 2'b00}, '0, was_hit);
        check_value("hit", 64'(1'b0), 64'(was_hit));

        for (i = 0; i < NUM_REQS; i++) begin
            wr   = 1'($urandom_range(1, 0));
            addr = {tag_pool[2'($urandom_range(3, 0))], 1'($urandom_range(1, 0)),
                    2'($urandom_range(3, 0))};
            run_request(wr, addr, word_t'($urandom), was_hit);
            if ($urandom_range(3, 0) == 0) begin
                @(posedge clk);
                cpu_req.valid <= 1'b0;
            end
        end

        $display("requests %0d, misses %0d, write-backs %0d", NUM_REQS + 6, miss_count,
                 wb_count);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: build.f
+incdir+include
hdl/cache_pkg.sv
hdl/cache_tag_array.sv
hdl/cache_data_array.sv
hdl/cache_hit_datapath.sv
hdl/cache_ctrl_fsm.sv
hdl/data_cache.sv
sim/data_cache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the data cache testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary -Iinclude -f build.f --top-module data_cache_tb -o data_cache_tb

sim_status=0
./obj_dir/data_cache_tb > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "simulation PASSED"
